// ==== Makefile ====
# Verilator build and run for the serial joystick reader

VERILATOR ?= verilator
TOP       ?= tb_joy_serial
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= *** PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/tb_joy_serial.sv ====
// directed testbench for the serial joystick reader
// shift register model, frame tests, checks and watchdog
`default_nettype none
`timescale 1ns/1ps

module tb_joy_serial;
  import joy_pkg::*;

  localparam int CLK_PERIOD   = 100;  // ns
  localparam int STIM_DLY     = 1;    // shift register model drives here
  localparam int CTRL_DLY     = 2;    // reset drive and sampling
  localparam int RESET_CYCLES = 5;
  localparam int FRAME_CYCLES = 26;
  localparam int FRAME_BITS   = 24;
  localparam int N_SINGLE     = 16;   // one main button per frame
  localparam int N_RANDOM     = 8;
  localparam int TEST_FRAMES  = 2 * (N_SINGLE + N_RANDOM) + 16;
  localparam int WATCHDOG_NS  = (TEST_FRAMES * FRAME_CYCLES + 100) * CLK_PERIOD;

  // stream order inside each group, first slot first
  localparam pad_bit_t MAIN_ORDER [8] = '{PAD_START, PAD_FIRE3, PAD_FIRE2, PAD_FIRE1,
                                          PAD_RIGHT, PAD_LEFT, PAD_DOWN, PAD_UP};
  localparam pad_bit_t EXTRA_ORDER [4] = '{PAD_SELECT, PAD_SYS, PAD_COIN, PAD_FIRE4};
  // pad bit feeding each core port bit, bit 0 first
  localparam pad_bit_t CORE_ORDER [8] = '{PAD_RIGHT, PAD_LEFT, PAD_DOWN, PAD_UP,
                                          PAD_FIRE1, PAD_FIRE2, PAD_FIRE3, PAD_START};

  logic                  ena_x;
  logic                  pll_locked;
  logic                  joy_data;
  logic                  joy_load;
  pad_t                  pad_1;
  pad_t                  pad_2;
  port_word_t            port_mouse;
  port_word_t            port_joy;
  logic [FRAME_BITS-1:0] frame_next;   // loaded at the next strobe
  logic [FRAME_BITS-1:0] frame_shift;  // inside the shift register
  int                    shift_pos;
  int                    seed;
  int                    n_checks;
  int                    n_errors;

  joy_serial_top joy_serial_top_inst (
    .ena_x      (ena_x),
    .pll_locked (pll_locked),
    .joy_data   (joy_data),
    .joy_load   (joy_load),
    .pad_1      (pad_1),
    .pad_2      (pad_2),
    .port_mouse (port_mouse),
    .port_joy   (port_joy)
  );

  initial
  begin
    ena_x = 1'b0;
    forever #(CLK_PERIOD / 2) ena_x = ~ena_x;
  end

  //////////////////////////////////////////////////////////////////////////////
  // shift register model
  //////////////////////////////////////////////////////////////////////////////

  initial
  begin
    joy_data    = 1'b1;  // released
    frame_shift = '1;
    shift_pos   = FRAME_BITS;
    forever
    begin
      @(posedge ena_x);
      #STIM_DLY;
      if (!pll_locked)
      begin
        shift_pos = FRAME_BITS;  // idle while held
        joy_data  = 1'b1;
      end
      else if (!joy_load)
      begin
        frame_shift = frame_next;  // parallel load, bits follow next cycle
        shift_pos   = 0;
        joy_data    = 1'b1;
      end
      else if (shift_pos < FRAME_BITS)
      begin
        joy_data  = frame_shift[shift_pos];
        shift_pos = shift_pos + 1;
      end
      else
      begin
        joy_data = 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////////
  // expected values
  //////////////////////////////////////////////////////////////////////////////

  // player 0: main bits 0..7, extras 20..23; player 1: main 8..15, extras 16..19
  function automatic pad_t expect_pad(input logic [FRAME_BITS-1:0] frame, input logic player);
    pad_t pad;
    int   main_base;
    int   extra_base;
    pad        = PAD_IDLE;
    main_base  = player ? 8 : 0;
    extra_base = player ? 16 : 20;
    for (int k = 0; k < 8; k++)
    begin
      pad[MAIN_ORDER[k]] = frame[main_base + k];
    end
    for (int k = 0; k < 4; k++)
    begin
      pad[EXTRA_ORDER[k]] = frame[extra_base + k];
    end
    return pad;
  endfunction

  function automatic port_word_t expect_port(input pad_t pad);
    port_word_t word;
    for (int b = 0; b < 8; b++)
    begin
      word[b] = pad[CORE_ORDER[b]];
    end
    return word;
  endfunction

  //////////////////////////////////////////////////////////////////////////////
  // checks and sync
  //////////////////////////////////////////////////////////////////////////////

  task automatic check_val(input string name, input logic [11:0] expected,
                           input logic [11:0] actual);
    n_checks++;
    assert (actual === expected)
    else
    begin
      n_errors++;
      $display("Error: %s expected 0x%h got 0x%h at %0t", name, expected, actual, $time);
    end
  endtask

  task automatic check_pads(input pad_t exp_1, input pad_t exp_2);
    check_val("pad_1", exp_1, pad_1);
    check_val("pad_2", exp_2, pad_2);
  endtask

  // mouse gets player 2, joystick player 1
  task automatic check_ports(input logic [FRAME_BITS-1:0] frame);
    check_val("port_mouse", 12'(expect_port(expect_pad(frame, 1'b1))), 12'(port_mouse));
    check_val("port_joy", 12'(expect_port(expect_pad(frame, 1'b0))), 12'(port_joy));
  endtask

  task automatic check_idle();
    check_val("joy_load", 12'(1'b1), 12'(joy_load));
    check_pads(PAD_IDLE, PAD_IDLE);
    check_val("port_mouse", 12'(PORT_IDLE), 12'(port_mouse));
    check_val("port_joy", 12'(PORT_IDLE), 12'(port_joy));
  endtask

  task automatic next_cycle();
    @(posedge ena_x);
    #CTRL_DLY;
  endtask

  // returns in slot 1, the model has just loaded frame_next
  task automatic wait_load_low();
    int n;
    n = 0;
    next_cycle();
    while (joy_load !== 1'b0 && n < 2 * FRAME_CYCLES)
    begin
      next_cycle();
      n++;
    end
    if (joy_load !== 1'b0)
    begin
      n_errors++;
      $display("joy_load never went low within two frames at %0t", $time);
    end
  endtask

  //////////////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////////////

  task automatic test_reset_values();
    repeat (RESET_CYCLES)
    begin
      next_cycle();
      check_idle();
    end
    pll_locked = 1'b1;
    check_idle();
    next_cycle();
    check_val("joy_load", 12'(1'b0), 12'(joy_load));  // first cycle after release
  endtask

  task automatic test_load_strobe();
    for (int f = 0; f < 3; f++)
    begin
      repeat (FRAME_CYCLES - 1)
      begin
        next_cycle();
        check_val("joy_load", 12'(1'b1), 12'(joy_load));
      end
      next_cycle();
      check_val("joy_load", 12'(1'b0), 12'(joy_load));
    end
  endtask

  // shift one frame, check pads and ports at the following strobe
  task automatic test_frame(input logic [FRAME_BITS-1:0] frame);
    frame_next = frame;
    wait_load_low();
    frame_next = '1;
    wait_load_low();
    check_pads(expect_pad(frame, 1'b0), expect_pad(frame, 1'b1));
    check_ports(frame);
  endtask

  task automatic test_single_buttons();
    for (int i = 0; i < N_SINGLE; i++)
    begin
      test_frame(~(24'd1 << i));
    end
  endtask

  task automatic test_random_frames();
    for (int i = 0; i < N_RANDOM; i++)
    begin
      test_frame(24'($random(seed)));
    end
  endtask

  // pads follow the stream, ports hold the old frame until after slot 25
  task automatic test_snapshot();
    logic [FRAME_BITS-1:0] frame_a;
    logic [FRAME_BITS-1:0] frame_b;
    logic [FRAME_BITS-1:0] mask;
    logic [FRAME_BITS-1:0] mix;
    frame_a    = 24'($random(seed));
    frame_b    = ~frame_a;  // every bit flips
    frame_next = frame_a;
    wait_load_low();
    frame_next = frame_b;
    wait_load_low();
    check_pads(expect_pad(frame_a, 1'b0), expect_pad(frame_a, 1'b1));
    check_ports(frame_a);
    frame_next = '1;
    for (int j = 1; j < FRAME_CYCLES; j++)
    begin
      next_cycle();
      mask = (24'd1 << (j - 1)) - 24'd1;  // samples already taken
      mix  = (frame_b & mask) | (frame_a & ~mask);
      check_pads(expect_pad(mix, 1'b0), expect_pad(mix, 1'b1));
      check_ports(frame_a);
    end
    wait_load_low();
    check_pads(expect_pad(frame_b, 1'b0), expect_pad(frame_b, 1'b1));
    check_ports(frame_b);
  endtask

  task automatic test_mid_reset();
    logic [FRAME_BITS-1:0] frame;
    frame_next = 24'($random(seed));
    wait_load_low();
    frame_next = '1;
    repeat (10)
    begin
      next_cycle();
    end
    pll_locked = 1'b0;  // async, mid frame
    #1;
    check_idle();
    repeat (2)
    begin
      next_cycle();
      check_idle();
    end
    frame      = 24'($random(seed));
    frame_next = frame;
    pll_locked = 1'b1;
    test_frame(frame);
  endtask

  //////////////////////////////////////////////////////////////////////////////
  // main and watchdog
  //////////////////////////////////////////////////////////////////////////////

  initial
  begin
    pll_locked = 1'b0;
    frame_next = '1;
    seed       = 32'h2f84_3d1d;
    n_checks   = 0;
    n_errors   = 0;
    test_reset_values();
    test_load_strobe();
    test_single_buttons();
    test_random_frames();
    test_snapshot();
    test_mid_reset();
    $display("checks: %0d  errors: %0d", n_checks, n_errors);
    if (n_errors == 0)
    begin
      $display("*** PASSED ***");
    end
    else
    begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial
  begin
    #(WATCHDOG_NS);
    n_errors++;
    $display("watchdog expired after %0d ns, tests did not complete", WATCHDOG_NS);
    $display("checks: %0d  errors: %0d", n_checks, n_errors);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== rtl/joy_capture.sv ====
// pad record registers for both players
// one joy_data bit written per commanded slot
`default_nettype none
`timescale 1ns/1ps

module joy_capture (
  input  wire logic                ena_x,
  input  wire logic                pll_locked,
  input  wire joy_pkg::slot_cmd_t  slot_cmd,
  input  wire logic                joy_data,     // from shift register, active low
  output joy_pkg::pad_t            pad_1,
  output joy_pkg::pad_t            pad_2
);
  import joy_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // write decode
  ////////////////////////////////////////////////////////////////////////////

  pad_t                   pad_q [NUM_PLAYERS];  // index 0 = player 1
  logic [NUM_PLAYERS-1:0] wr_en;                // one hot or zero
  pad_t                   bit_mask;             // commanded bit position

  // shared by both records, only wr_en differs
  assign bit_mask = pad_t'(1) << slot_cmd.bit_idx;

  ////////////////////////////////////////////////////////////////////////////
  // pad records
  ////////////////////////////////////////////////////////////////////////////

  for (genvar p = 0; p < NUM_PLAYERS; p++)
  begin : g_player

    // this player's turn in the slot table
    assign wr_en[p] = slot_cmd.valid && (slot_cmd.player == 1'(p));

    always_ff @(posedge ena_x or negedge pll_locked)
    begin
      if (!pll_locked)
      begin
        pad_q[p] <= PAD_IDLE;   // nothing pressed
      end
      else if (wr_en[p])
      begin
        // replace the one bit, keep the rest
        pad_q[p] <= (pad_q[p] & ~bit_mask) | (joy_data ? bit_mask : '0);
      end
    end

  end

  ////////////////////////////////////////////////////////////////////////////
  // outputs
  ////////////////////////////////////////////////////////////////////////////

  // pads follow the stream, updated bit by bit within the frame
  assign pad_1 = pad_q[0];
  assign pad_2 = pad_q[1];

endmodule

`default_nettype wire

// ==== rtl/joy_pkg.sv ====
// shared widths, slot constants, pad bit indices and slot command struct
// for the two-player serial joystick reader
`default_nettype none

package joy_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [4:0]  frame_count_t;  // slot number within a frame
  typedef logic [11:0] pad_t;          // one player, active low
  typedef logic [7:0]  port_word_t;    // core joystick word, active low
  typedef logic [3:0]  pad_bit_t;      // index into a pad record

  // one bit-write per sampled slot
  typedef struct packed {
    logic     valid;    // slot carries a button bit
    logic     player;   // 0 = player 1, 1 = player 2
    pad_bit_t bit_idx;  // target bit in that player's record
  } slot_cmd_t;

  ////////////////////////////////////////////////////////////////////////////
  // frame sequencing
  ////////////////////////////////////////////////////////////////////////////

  localparam frame_count_t FRAME_LAST = 5'd25;  // wraps to 0 after this
  localparam frame_count_t LOAD_SLOT  = 5'd1;   // load strobe low here
  localparam frame_count_t FIRST_SLOT = 5'd2;   // first data bit

  localparam int NUM_PLAYERS = 2;
  localparam logic PLAYER_1  = 1'b0;
  localparam logic PLAYER_2  = 1'b1;

  // released values, all buttons up
  localparam pad_t       PAD_IDLE  = 12'hfff;
  localparam port_word_t PORT_IDLE = 8'hff;

  ////////////////////////////////////////////////////////////////////////////
  // pad record layout
  ////////////////////////////////////////////////////////////////////////////

  localparam pad_bit_t PAD_UP     = 4'd0;
  localparam pad_bit_t PAD_DOWN   = 4'd1;
  localparam pad_bit_t PAD_LEFT   = 4'd2;
  localparam pad_bit_t PAD_RIGHT  = 4'd3;
  localparam pad_bit_t PAD_FIRE1  = 4'd4;
  localparam pad_bit_t PAD_FIRE2  = 4'd5;
  localparam pad_bit_t PAD_FIRE3  = 4'd6;
  localparam pad_bit_t PAD_FIRE4  = 4'd7;
  localparam pad_bit_t PAD_START  = 4'd8;
  localparam pad_bit_t PAD_COIN   = 4'd9;
  localparam pad_bit_t PAD_SELECT = 4'd10;
  localparam pad_bit_t PAD_SYS    = 4'd11;  // service on p1, test on p2

endpackage

`default_nettype wire

// ==== rtl/joy_port_map.sv ====
// per-frame snapshot of both pads into core joystick words
// mouse port carries player 2, joystick port player 1
`default_nettype none
`timescale 1ns/1ps

module joy_port_map (
  input  wire logic           ena_x,
  input  wire logic           pll_locked,
  input  wire logic           frame_start,   // high while count is 0
  input  wire joy_pkg::pad_t  pad_1,
  input  wire joy_pkg::pad_t  pad_2,
  output joy_pkg::port_word_t port_mouse,
  output joy_pkg::port_word_t port_joy
);
  import joy_pkg::*;

  port_word_t mouse_q;
  port_word_t joy_q;

  // core order, msb first
  // start, fire3, fire2, fire1, up, down, left, right
  function automatic port_word_t to_port(input pad_t pad);
    return {pad[PAD_START], pad[PAD_FIRE3], pad[PAD_FIRE2], pad[PAD_FIRE1],
            pad[PAD_UP],    pad[PAD_DOWN],  pad[PAD_LEFT],  pad[PAD_RIGHT]};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // snapshot
  ////////////////////////////////////////////////////////////////////////////

  // edge ending count 0 follows slot 25, so the pads hold a whole frame
  always_ff @(posedge ena_x or negedge pll_locked)
  begin
    if (!pll_locked)
    begin
      mouse_q <= PORT_IDLE;
      joy_q   <= PORT_IDLE;
    end
    else if (frame_start)
    begin
      mouse_q <= to_port(pad_2);   // swapped, as on the board
      joy_q   <= to_port(pad_1);
    end
  end

  // stable for the whole next frame
  assign port_mouse = mouse_q;
  assign port_joy   = joy_q;

endmodule

`default_nettype wire

// ==== rtl/joy_serial_top.sv ====
// serial joystick reader top
// slot decode, bit capture and port snapshot stages
`default_nettype none
`timescale 1ns/1ps

module joy_serial_top (
  input  wire logic           ena_x,        // also the shift register clock
  input  wire logic           pll_locked,
  input  wire logic           joy_data,     // serial in, active low
  output logic                joy_load,     // parallel load, active low
  output joy_pkg::pad_t       pad_1,
  output joy_pkg::pad_t       pad_2,
  output joy_pkg::port_word_t port_mouse,
  output joy_pkg::port_word_t port_joy
);
  import joy_pkg::*;

  slot_cmd_t slot_cmd;      // decode to capture
  logic      frame_start;   // decode to port map

  ////////////////////////////////////////////////////////////////////////////
  // slot sequencing
  ////////////////////////////////////////////////////////////////////////////

  joy_slot_decode joy_slot_decode_inst (
    .ena_x       (ena_x),
    .pll_locked  (pll_locked),
    .slot_cmd    (slot_cmd),
    .frame_start (frame_start),
    .joy_load    (joy_load)
  );

  ////////////////////////////////////////////////////////////////////////////
  // bit capture
  ////////////////////////////////////////////////////////////////////////////

  joy_capture joy_capture_inst (
    .ena_x      (ena_x),
    .pll_locked (pll_locked),
    .slot_cmd   (slot_cmd),
    .joy_data   (joy_data),
    .pad_1      (pad_1),       // also out to the top
    .pad_2      (pad_2)
  );

  ////////////////////////////////////////////////////////////////////////////
  // core ports
  ////////////////////////////////////////////////////////////////////////////

  joy_port_map joy_port_map_inst (
    .ena_x       (ena_x),
    .pll_locked  (pll_locked),
    .frame_start (frame_start),
    .pad_1       (pad_1),
    .pad_2       (pad_2),
    .port_mouse  (port_mouse),  // player 2
    .port_joy    (port_joy)     // player 1
  );

endmodule

`default_nettype wire

// ==== rtl/joy_slot_decode.sv ====
// frame counter, registered load strobe, frame-start level
// and slot table decode into bit-write commands
`default_nettype none
`timescale 1ns/1ps

module joy_slot_decode (
  input  wire logic              ena_x,
  input  wire logic              pll_locked,
  output joy_pkg::slot_cmd_t     slot_cmd,
  output logic                   frame_start,
  output logic                   joy_load
);
  import joy_pkg::*;

  frame_count_t count_q;
  frame_count_t count_next;
  frame_count_t slot_pos;   // count relative to first data slot
  logic         load_n_q;   // registered, low in LOAD_SLOT
  slot_cmd_t    cmd;

  // main buttons arrive start first, up last
  function automatic pad_bit_t main_bit(input logic [2:0] pos);
    case (pos)
      3'd0:    return PAD_START;
      3'd1:    return PAD_FIRE3;
      3'd2:    return PAD_FIRE2;
      3'd3:    return PAD_FIRE1;
      3'd4:    return PAD_RIGHT;
      3'd5:    return PAD_LEFT;
      3'd6:    return PAD_DOWN;
      default: return PAD_UP;
    endcase
  endfunction

  // extras: select, sys, coin, fire4
  function automatic pad_bit_t extra_bit(input logic [1:0] pos);
    case (pos)
      2'd0:    return PAD_SELECT;
      2'd1:    return PAD_SYS;
      2'd2:    return PAD_COIN;
      default: return PAD_FIRE4;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // sequencing
  ////////////////////////////////////////////////////////////////////////////

  assign count_next = (count_q == FRAME_LAST) ? '0 : frame_count_t'(count_q + 5'd1);

  always_ff @(posedge ena_x or negedge pll_locked)
  begin
    if (!pll_locked)
    begin
      count_q  <= '0;
      load_n_q <= 1'b1;   // shift register idle
    end
    else
    begin
      count_q  <= count_next;
      load_n_q <= (count_next != LOAD_SLOT);   // low for one slot per frame
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // slot table
  ////////////////////////////////////////////////////////////////////////////

  assign slot_pos = frame_count_t'(count_q - FIRST_SLOT);  // wraps for slots 0,1

  always_comb
  begin
    cmd.valid   = (count_q >= FIRST_SLOT);  // counter never passes FRAME_LAST
    cmd.player  = PLAYER_1;
    cmd.bit_idx = PAD_UP;
    if (!slot_pos[4])
    begin
      // slots 2..17, p1 then p2 main buttons
      cmd.player  = slot_pos[3] ? PLAYER_2 : PLAYER_1;
      cmd.bit_idx = main_bit(slot_pos[2:0]);
    end
    else
    begin
      // slots 18..25, p2 extras before p1 extras
      cmd.player  = slot_pos[2] ? PLAYER_1 : PLAYER_2;
      cmd.bit_idx = extra_bit(slot_pos[1:0]);
    end
  end

  assign slot_cmd    = cmd;
  assign frame_start = (count_q == '0);
  assign joy_load    = load_n_q;

endmodule

`default_nettype wire

// ==== src.f ====
rtl/joy_pkg.sv
rtl/joy_slot_decode.sv
rtl/joy_capture.sv
rtl/joy_port_map.sv
rtl/joy_serial_top.sv
dv/tb_joy_serial.sv
